/* bp_btb.sv */
/* Direct-mapped tagged BTB, one way only
   Written on taken non-return retires, aliasing PCs replace each other */
`timescale 1ns/1ps

module bp_btb (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [bp_pkg::PC_W-1:0]  lookup_pc,
	output logic                     hit,
	output logic [bp_pkg::PC_W-1:0]  target,
	bp_update_if.sink                update
);
	import bp_pkg::*;

	logic [BTB_ENTRIES-1:0] valid;
	logic [BTB_TAG_W-1:0]   tags    [BTB_ENTRIES];
	logic [PC_W-1:0]        targets [BTB_ENTRIES];

	logic [BTB_IDX_W-1:0]   rd_idx;
	logic [BTB_TAG_W-1:0]   rd_tag;
	logic [BTB_IDX_W-1:0]   wr_idx;
	logic [BTB_TAG_W-1:0]   wr_tag;
	logic                   write;

	// ------------------------------
	// Lookup
	// ------------------------------
	// Index just above bit 1, tag right above the index
	assign rd_idx = lookup_pc[BTB_IDX_W+1:2];
	assign rd_tag = lookup_pc[BTB_TAG_W+BTB_IDX_W+1:BTB_IDX_W+2];
	assign hit    = valid[rd_idx] && (tags[rd_idx] == rd_tag);
	assign target = targets[rd_idx];

	// ------------------------------
	// Retire write
	// ------------------------------
	assign wr_idx = update.pc[BTB_IDX_W+1:2];
	assign wr_tag = update.pc[BTB_TAG_W+BTB_IDX_W+1:BTB_IDX_W+2];
	// Returns go through the RAS
	assign write  = update.valid && update.taken && (update.kind != kind_ret);

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (write) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (write) begin
			tags[wr_idx]    <= wr_tag;
			targets[wr_idx] <= update.target;
		end
	end

endmodule

/* bp_gshare.sv */
/* Gshare direction predictor, index is pc[GHR_W+1:2] xor history
   Retire restore wins over a lookup shift in the same cycle */
`timescale 1ns/1ps

module bp_gshare (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      lookup,
	input  logic                      lookup_cond,
	input  logic [bp_pkg::PC_W-1:0]   lookup_pc,
	output logic                      predict_taken,
	output logic [bp_pkg::GHR_W-1:0]  history,
	bp_update_if.sink                 update,
	input  logic [bp_pkg::GHR_W-1:0]  checkpoint
);
	import bp_pkg::*;

	// Counter table, 1 = weakly not taken
	logic [1:0]       pht [PHT_ENTRIES];
	logic [GHR_W-1:0] lookup_idx;
	logic [GHR_W-1:0] train_idx;
	logic             train;
	logic             restore;

	// ------------------------------
	// Lookup side
	// ------------------------------
	assign lookup_idx    = lookup_pc[GHR_W+1:2] ^ history;
	assign predict_taken = pht[lookup_idx][1];

	// ------------------------------
	// Retire side
	// ------------------------------
	// Counter the branch used at lookup, found via its checkpoint
	assign train_idx = update.pc[GHR_W+1:2] ^ checkpoint;
	assign train     = update.valid && (update.kind == kind_cond);
	assign restore   = train && !update.correct;

	// History register
	always_ff @(posedge clock) begin
		if (reset) begin
			history <= '0;
		end else if (restore) begin
			// Rebuild from checkpoint with the real outcome
			history <= {checkpoint[GHR_W-2:0], update.taken};
		end else if (lookup && lookup_cond) begin
			// Speculative shift of the predicted bit
			history <= {history[GHR_W-2:0], predict_taken};
		end
	end

	// Saturating 2-bit counters
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				pht[i] <= 2'd1;
			end
		end else if (train) begin
			if (update.taken) begin
				if (pht[train_idx] != 2'd3)
					pht[train_idx] <= pht[train_idx] + 2'd1;
			end else begin
				if (pht[train_idx] != 2'd0)
					pht[train_idx] <= pht[train_idx] - 2'd1;
			end
		end
	end

endmodule

/* bp_history_queue.sv */
/* Circular queue of history checkpoints, retires in order
   Push while full overwrites a live entry; the fetch side must avoid it */
`timescale 1ns/1ps

module bp_history_queue (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      push,
	input  logic [bp_pkg::GHR_W-1:0]  history_in,
	output bp_pkg::hq_tag_t           push_tag,
	bp_update_if.sink                 update,
	output logic [bp_pkg::GHR_W-1:0]  checkpoint,
	output logic                      full
);
	import bp_pkg::*;

	logic [GHR_W-1:0] entries [HQ_DEPTH];
	hq_tag_t          tail;
	// One wider than a tag so full is visible
	logic [HQ_TAG_W:0] count;
	logic             retire;
	logic             flush;

	// Tag is the slot the checkpoint lands in
	assign push_tag   = tail;
	assign checkpoint = entries[update.tag];
	assign full       = (count == (HQ_TAG_W+1)'(HQ_DEPTH));

	assign retire = update.valid && (update.kind == kind_cond) && update.correct;
	assign flush  = update.valid && (update.kind == kind_cond) && !update.correct;

	// ------------------------------
	// Pointers
	// ------------------------------
	// Oldest entry sits count slots behind tail
	always_ff @(posedge clock) begin
		if (reset) begin
			tail  <= '0;
			count <= '0;
		end else if (flush) begin
			// Younger entries are wrong path, drop everything
			tail  <= update.tag + 1'b1;
			count <= '0;
		end else begin
			if (push)
				tail <= tail + 1'b1;
			if (push && !retire)
				count <= count + 1'b1;
			else if (retire && !push)
				count <= count - 1'b1;
		end
	end

	// Checkpoint storage
	always_ff @(posedge clock) begin
		if (push && !flush)
			entries[tail] <= history_in;
	end

endmodule

/* bp_pkg.sv */
/* Sizes and shared types for the branch predictor
   PC_W above 2 + BTB index + BTB tag bits, table sizes are powers of two */
package bp_pkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int PC_W        = 32;
	localparam int GHR_W       = 8;
	localparam int PHT_ENTRIES = 2 ** GHR_W;

	// Direct mapped, indexed by pc[BTB_IDX_W+1:2]
	localparam int BTB_ENTRIES = 64;
	localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
	localparam int BTB_TAG_W   = 8;

	localparam int RAS_DEPTH   = 8;
	localparam int RAS_PTR_W   = $clog2(RAS_DEPTH);

	// One checkpoint per cond branch in flight
	localparam int HQ_DEPTH    = 8;
	localparam int HQ_TAG_W    = 3;

	// ------------------------------
	// Types
	// ------------------------------
	typedef enum logic [1:0] {
		kind_cond = 2'd0,
		kind_jump = 2'd1,
		kind_call = 2'd2,
		kind_ret  = 2'd3
	} branch_kind_t;

	// Queue position of a history checkpoint
	typedef logic [HQ_TAG_W-1:0] hq_tag_t;

endpackage

/* bp_ras.sv */
/* Circular return address stack, not repaired on mispredicts
   Push when full drops the oldest address */
`timescale 1ns/1ps

module bp_ras (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     push,
	input  logic                     pop,
	input  logic [bp_pkg::PC_W-1:0]  push_pc,
	output logic [bp_pkg::PC_W-1:0]  top,
	output logic                     non_empty
);
	import bp_pkg::*;

	logic [PC_W-1:0]      stack [RAS_DEPTH];
	// Next free slot, wraps around
	logic [RAS_PTR_W-1:0] ptr;
	logic [RAS_PTR_W:0]   count;

	assign top       = stack[ptr - 1'b1];
	assign non_empty = (count != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			ptr   <= '0;
			count <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
			// Saturate, oldest slot gets reused
			if (count != (RAS_PTR_W+1)'(RAS_DEPTH))
				count <= count + 1'b1;
		end else if (pop && non_empty) begin
			ptr   <= ptr - 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			stack[ptr] <= push_pc;
	end

endmodule

/* bp_select.sv */
/* Second stage, next-PC choice and prediction register
   pred_tag only means something for cond branches */
`timescale 1ns/1ps

module bp_select (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     stage_valid,
	input  bp_pkg::branch_kind_t     stage_kind,
	input  logic [bp_pkg::PC_W-1:0]  stage_pc,
	input  logic                     predict_taken,
	input  logic                     btb_hit,
	input  logic [bp_pkg::PC_W-1:0]  btb_target,
	input  logic                     ras_valid,
	input  logic [bp_pkg::PC_W-1:0]  ras_top,
	input  bp_pkg::hq_tag_t          stage_tag,
	output logic                     pred_valid,
	output logic [bp_pkg::PC_W-1:0]  pred_pc,
	output logic                     pred_taken,
	output bp_pkg::hq_tag_t          pred_tag
);
	import bp_pkg::*;

	logic            use_target;
	logic [PC_W-1:0] next_pc;

	// Taken only when a real target is known
	always_comb begin
		unique case (stage_kind)
			kind_cond: use_target = predict_taken && btb_hit;
			kind_jump: use_target = btb_hit;
			kind_call: use_target = btb_hit;
			kind_ret:  use_target = ras_valid;
			default:   use_target = 1'b0;
		endcase
		if (!use_target)
			next_pc = stage_pc + PC_W'(4);
		else if (stage_kind == kind_ret)
			next_pc = ras_top;
		else
			next_pc = btb_target;
	end

	always_ff @(posedge clock) begin
		if (reset)
			pred_valid <= 1'b0;
		else
			pred_valid <= stage_valid;
	end

	// Payload
	always_ff @(posedge clock) begin
		pred_pc    <= next_pc;
		pred_taken <= use_target;
		pred_tag   <= stage_tag;
	end

endmodule

/* bp_update_if.sv */
/* Retire update bus toward the storage blocks
   valid is a single-cycle strobe, no back-pressure */
`timescale 1ns/1ps

interface bp_update_if;

	logic                      valid;
	bp_pkg::branch_kind_t      kind;
	logic [bp_pkg::PC_W-1:0]   pc;
	// Resolved target of the branch
	logic [bp_pkg::PC_W-1:0]   target;
	logic                      taken;
	// Low when the prediction was wrong
	logic                      correct;
	bp_pkg::hq_tag_t           tag;

	// Top level drives
	modport source (output valid, kind, pc, target, taken, correct, tag);

	// BTB, gshare and history queue read
	modport sink (input valid, kind, pc, target, taken, correct, tag);

endinterface

/* branch_predictor.sv */
/* Fetch-side branch predictor, two-stage lookup with retire training
   At most HQ_DEPTH cond branches in flight, strobes have no back-pressure */
`timescale 1ns/1ps

module branch_predictor (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     lookup_valid,
	input  bp_pkg::branch_kind_t     lookup_kind,
	input  logic [bp_pkg::PC_W-1:0]  lookup_pc,
	input  logic                     retire_valid,
	input  bp_pkg::branch_kind_t     retire_kind,
	input  logic [bp_pkg::PC_W-1:0]  retire_pc,
	input  logic [bp_pkg::PC_W-1:0]  retire_target,
	input  logic                     retire_taken,
	input  logic                     retire_correct,
	input  bp_pkg::hq_tag_t          retire_tag,
	output logic                     pred_valid,
	output logic [bp_pkg::PC_W-1:0]  pred_pc,
	output logic                     pred_taken,
	output bp_pkg::hq_tag_t          pred_tag
);
	import bp_pkg::*;

	bp_update_if update_bus ();

	logic             lookup_cond;
	logic             hq_push;
	logic             ras_push;
	logic             ras_pop;
	logic             gs_taken;
	logic [GHR_W-1:0] history;
	logic [GHR_W-1:0] checkpoint;
	hq_tag_t          push_tag;
	logic             btb_hit;
	logic [PC_W-1:0]  btb_target;
	logic [PC_W-1:0]  ras_top;
	logic             ras_non_empty;

	// Stage-1 registers
	logic             s1_valid;
	branch_kind_t     s1_kind;
	logic [PC_W-1:0]  s1_pc;
	logic             s1_taken;
	logic             s1_hit;
	logic [PC_W-1:0]  s1_target;
	hq_tag_t          s1_tag;
	logic             s1_ras_valid;
	logic [PC_W-1:0]  s1_ras_top;

	// ------------------------------
	// Retire bus and kind decode
	// ------------------------------
	assign update_bus.valid   = retire_valid;
	assign update_bus.kind    = retire_kind;
	assign update_bus.pc      = retire_pc;
	assign update_bus.target  = retire_target;
	assign update_bus.taken   = retire_taken;
	assign update_bus.correct = retire_correct;
	assign update_bus.tag     = retire_tag;

	assign lookup_cond = (lookup_kind == kind_cond);
	assign hq_push     = lookup_valid && lookup_cond;
	assign ras_push    = lookup_valid && (lookup_kind == kind_call);
	assign ras_pop     = lookup_valid && (lookup_kind == kind_ret);

	// ------------------------------
	// Storage blocks
	// ------------------------------
	bp_gshare gshare_inst (
		.clock(clock), .reset(reset), .lookup(lookup_valid), .lookup_cond(lookup_cond),
		.lookup_pc(lookup_pc), .predict_taken(gs_taken), .history(history),
		.update(update_bus), .checkpoint(checkpoint)
	);

	// Checkpoint is the history before this branch shifts in
	bp_history_queue queue_inst (
		.clock(clock), .reset(reset), .push(hq_push), .history_in(history),
		.push_tag(push_tag), .update(update_bus), .checkpoint(checkpoint), .full()
	);

	bp_btb btb_inst (
		.clock(clock), .reset(reset), .lookup_pc(lookup_pc), .hit(btb_hit),
		.target(btb_target), .update(update_bus)
	);

	// Return address is the instruction after the call
	bp_ras ras_inst (
		.clock(clock), .reset(reset), .push(ras_push), .pop(ras_pop),
		.push_pc(lookup_pc + PC_W'(4)), .top(ras_top), .non_empty(ras_non_empty)
	);

	// ------------------------------
	// Stage 1
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= lookup_valid;
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			s1_kind      <= lookup_kind;
			s1_pc        <= lookup_pc;
			s1_taken     <= gs_taken;
			s1_hit       <= btb_hit;
			s1_target    <= btb_target;
			s1_tag       <= push_tag;
			// Top before the pop of this return
			s1_ras_valid <= ras_non_empty;
			s1_ras_top   <= ras_top;
		end
	end

	bp_select select_inst (
		.clock(clock), .reset(reset), .stage_valid(s1_valid), .stage_kind(s1_kind),
		.stage_pc(s1_pc), .predict_taken(s1_taken), .btb_hit(s1_hit),
		.btb_target(s1_target), .ras_valid(s1_ras_valid), .ras_top(s1_ras_top),
		.stage_tag(s1_tag), .pred_valid(pred_valid), .pred_pc(pred_pc),
		.pred_taken(pred_taken), .pred_tag(pred_tag)
	);

endmodule

/* branch_predictor_sva.sv */
/* Strobe and queue protocol assertions, bound to the history queue and bp_select
   Ports that a binding does not use are tied low */
`timescale 1ns/1ps

module branch_predictor_sva (
	input logic clock,
	input logic reset,
	input logic push,
	input logic full,
	input logic stage_valid,
	input logic pred_valid
);

	// At most HQ_DEPTH cond branches in flight
	assert property (@(posedge clock) disable iff (reset) !(push && full))
		else $error("history queue pushed while full");

	// stage_valid is the lookup one edge late, so two edges to pred_valid
	assert property (@(posedge clock) disable iff (reset) stage_valid |=> pred_valid)
		else $error("pred_valid missing two cycles after a lookup");

	assert property (@(posedge clock) disable iff (reset) !stage_valid |=> !pred_valid)
		else $error("pred_valid without a lookup");

	assert property (@(posedge clock) reset |=> !pred_valid)
		else $error("pred_valid high right after reset");

endmodule

bind bp_history_queue branch_predictor_sva queue_sva_inst (
	.clock(clock), .reset(reset), .push(push), .full(full),
	.stage_valid(1'b0), .pred_valid(1'b0)
);

bind bp_select branch_predictor_sva select_sva_inst (
	.clock(clock), .reset(reset), .push(1'b0), .full(1'b0),
	.stage_valid(stage_valid), .pred_valid(pred_valid)
);

/* filelist.f */
bp_pkg.sv
bp_update_if.sv
bp_gshare.sv
bp_history_queue.sv
bp_btb.sv
bp_ras.sv
bp_select.sv
branch_predictor.sv
branch_predictor_sva.sv
tb_branch_predictor.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, pass only when the testbench reports success
verilator --binary --assert -f filelist.f --top-module tb_branch_predictor -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "TEST OK" \
	|| { echo "simulation did not pass"; exit 1; }

/* tb_branch_predictor.sv */
/* Directed testbench with its own model of history, counters, BTB, RAS and queue
   Assumes no lookup and retire in the same cycle, so the model can update in order */
`timescale 1ns/1ps

module tb_branch_predictor;
	import bp_pkg::*;

	localparam logic [31:0] MAX_CYCLES = 32'd2000;

	typedef struct packed {
		logic [31:0] cycle;
		logic [31:0] pc;
		logic        taken;
		hq_tag_t     tag;
		logic        cond;
	} expect_t;

	logic            clock;
	logic            reset;
	logic            lookup_valid;
	branch_kind_t    lookup_kind;
	logic [PC_W-1:0] lookup_pc;
	logic            retire_valid;
	branch_kind_t    retire_kind;
	logic [PC_W-1:0] retire_pc;
	logic [PC_W-1:0] retire_target;
	logic            retire_taken;
	logic            retire_correct;
	hq_tag_t         retire_tag;
	logic            pred_valid;
	logic [PC_W-1:0] pred_pc;
	logic            pred_taken;
	hq_tag_t         pred_tag;

	logic [31:0] cycle = 32'd0;
	int          errors;
	string       test_name;
	logic [31:0] rng;
	expect_t     exp_q[$];

	// ------------------------------
	// Reference model state
	// ------------------------------
	logic [GHR_W-1:0] m_ghr;
	logic [1:0]       m_pht [PHT_ENTRIES];
	logic             m_btb_valid [BTB_ENTRIES];
	logic [7:0]       m_btb_tag [BTB_ENTRIES];
	logic [31:0]      m_btb_target [BTB_ENTRIES];
	logic [31:0]      m_ras [RAS_DEPTH];
	int               m_ras_ptr;
	int               m_ras_count;
	logic [GHR_W-1:0] m_hq [HQ_DEPTH];
	hq_tag_t          m_tail;
	hq_tag_t          m_last_tag;
	logic             m_predicted;

	branch_predictor branch_predictor_inst (
		.clock(clock), .reset(reset), .lookup_valid(lookup_valid),
		.lookup_kind(lookup_kind), .lookup_pc(lookup_pc), .retire_valid(retire_valid),
		.retire_kind(retire_kind), .retire_pc(retire_pc), .retire_target(retire_target),
		.retire_taken(retire_taken), .retire_correct(retire_correct),
		.retire_tag(retire_tag), .pred_valid(pred_valid), .pred_pc(pred_pc),
		.pred_taken(pred_taken), .pred_tag(pred_tag)
	);

	always #5 clock = ~clock;

	// Cycle count and run limit
	always @(posedge clock) begin
		cycle <= cycle + 32'd1;
		if (cycle == MAX_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ------------------------------
	// Prediction checker
	// ------------------------------
	// Outputs sampled at the falling edge, half a cycle after they change
	task automatic check_predictions();
		expect_t e;
		forever begin
			@(negedge clock);
			if (!reset && pred_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: prediction came out with no lookup behind it", test_name);
				end else begin
					e = exp_q.pop_front();
					compare({test_name, " cycle"}, e.cycle, cycle);
					compare({test_name, " pc"}, e.pc, pred_pc);
					compare({test_name, " taken"}, 32'(e.taken), 32'(pred_taken));
					if (e.cond)
						compare({test_name, " tag"}, 32'(e.tag), 32'(pred_tag));
				end
			end else if (exp_q.size() != 0 && exp_q[0].cycle < cycle) begin
				errors++;
				$display("%s: no prediction two cycles after a lookup", test_name);
				void'(exp_q.pop_front());
			end
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clock);
		#1;
	endtask

	// ------------------------------
	// Drivers with model update
	// ------------------------------
	task automatic lookup(input branch_kind_t kind, input logic [31:0] pc);
		expect_t    e;
		logic [7:0] idx;
		logic [5:0] bidx;
		logic       hit;
		logic       use_target;
		idx = pc[9:2] ^ m_ghr;
		bidx = pc[7:2];
		hit = m_btb_valid[bidx] && (m_btb_tag[bidx] == pc[15:8]);
		m_predicted = m_pht[idx][1];
		case (kind)
			kind_cond: use_target = m_predicted && hit;
			kind_jump, kind_call: use_target = hit;
			kind_ret: use_target = (m_ras_count != 0);
		endcase
		e.pc = pc + 32'd4;
		if (use_target)
			e.pc = (kind == kind_ret) ? m_ras[(m_ras_ptr + 7) % 8] : m_btb_target[bidx];
		e.taken = use_target;
		e.tag = m_tail;
		e.cond = (kind == kind_cond);
		if (kind == kind_cond) begin
			// Checkpoint is the history before the shift
			m_hq[m_tail] = m_ghr;
			m_last_tag = m_tail;
			m_tail = m_tail + hq_tag_t'(1);
			m_ghr = {m_ghr[6:0], m_predicted};
		end else if (kind == kind_call) begin
			m_ras[m_ras_ptr] = pc + 32'd4;
			m_ras_ptr = (m_ras_ptr + 1) % 8;
			if (m_ras_count < 8)
				m_ras_count++;
		end else if (kind == kind_ret && m_ras_count != 0) begin
			m_ras_ptr = (m_ras_ptr + 7) % 8;
			m_ras_count--;
		end
		lookup_valid = 1'b1;
		lookup_kind = kind;
		lookup_pc = pc;
		@(posedge clock);
		#1;
		// Visible after the next edge, sampled high at the one after
		e.cycle = cycle + 32'd1;
		exp_q.push_back(e);
		lookup_valid = 1'b0;
	endtask

	task automatic retire(input branch_kind_t kind, input logic [31:0] pc,
			input logic [31:0] target, input logic taken, input logic correct,
			input hq_tag_t tag);
		logic [7:0] idx;
		logic [5:0] bidx;
		if (kind == kind_cond) begin
			idx = pc[9:2] ^ m_hq[tag];
			if (taken && m_pht[idx] != 2'd3)
				m_pht[idx] = m_pht[idx] + 2'd1;
			else if (!taken && m_pht[idx] != 2'd0)
				m_pht[idx] = m_pht[idx] - 2'd1;
			if (!correct) begin
				m_ghr = {m_hq[tag][6:0], taken};
				m_tail = tag + hq_tag_t'(1);
			end
		end
		if (taken && kind != kind_ret) begin
			bidx = pc[7:2];
			m_btb_valid[bidx] = 1'b1;
			m_btb_tag[bidx] = pc[15:8];
			m_btb_target[bidx] = target;
		end
		retire_valid = 1'b1;
		retire_kind = kind;
		retire_pc = pc;
		retire_target = target;
		retire_taken = taken;
		retire_correct = correct;
		retire_tag = tag;
		@(posedge clock);
		#1;
		retire_valid = 1'b0;
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_reset_latency();
		test_name = "reset_latency";
		lookup(kind_cond, 32'h0000_1000);
		drain();
		// Back to back, one per cycle
		lookup(kind_cond, 32'h0000_2004);
		lookup(kind_jump, 32'h0000_2008);
		lookup(kind_cond, 32'h0000_200c);
		lookup(kind_jump, 32'h0000_2010);
		drain();
	endtask

	task automatic test_btb();
		test_name = "btb";
		lookup(kind_jump, 32'h0000_3040);
		retire(kind_jump, 32'h0000_3040, 32'h0000_8000, 1'b1, 1'b0, '0);
		lookup(kind_jump, 32'h0000_3040);
		// Same index, tag differs in bit 8
		lookup(kind_jump, 32'h0000_3140);
		drain();
	endtask

	task automatic test_gshare();
		test_name = "gshare";
		for (int i = 0; i < 16 && m_pht[8'h84 ^ m_ghr] < 2'd2; i++) begin
			lookup(kind_cond, 32'h0000_4a10);
			retire(kind_cond, 32'h0000_4a10, 32'h0000_9000, 1'b1, 1'b0, m_last_tag);
		end
		lookup(kind_cond, 32'h0000_4a10);
		// Counter reached weakly taken, so the direction bit is set
		compare("gshare trained", 32'd1, 32'(branch_predictor_inst.s1_taken));
		retire(kind_cond, 32'h0000_4a10, 32'h0000_9000, 1'b1, 1'b1, m_last_tag);
		drain();
		test_name = "gshare_random";
		for (int i = 0; i < 20; i++) begin
			logic [31:0] pc;
			logic [31:0] tgt;
			rng = xorshift(rng);
			pc = {rng[31:2], 2'b00};
			rng = xorshift(rng);
			tgt = {rng[31:2], 2'b00};
			lookup(kind_cond, pc);
			retire(kind_cond, pc, tgt, rng[7], rng[7] == m_predicted, m_last_tag);
		end
		drain();
	endtask

	task automatic test_history_recovery();
		logic [GHR_W-1:0] cp0;
		hq_tag_t          t0;
		hq_tag_t          t1;
		test_name = "history_recovery";
		cp0 = m_ghr;
		t0 = m_tail;
		t1 = t0 + hq_tag_t'(1);
		for (int i = 0; i < 4; i++)
			lookup(kind_cond, 32'h0000_5100 + i * 32'h24);
		retire(kind_cond, 32'h0000_5100, 32'h0000_5400, 1'b1, 1'b0, t0);
		compare("history restore", 32'({cp0[6:0], 1'b1}),
			32'(branch_predictor_inst.gshare_inst.history));
		// First lookup after the flush takes the slot after the retired tag
		lookup(kind_cond, 32'h0000_5000);
		@(posedge clock);
		#1;
		compare("tag after flush", 32'(t1), 32'(pred_tag));
		retire(kind_cond, 32'h0000_5000, 32'h0000_5800, m_predicted, 1'b1, m_last_tag);
		drain();
	endtask

	task automatic test_ras();
		test_name = "ras";
		lookup(kind_ret, 32'h0000_6000);
		for (int i = 0; i < 3; i++)
			lookup(kind_call, 32'h0000_6100 + i * 32'h40);
		for (int i = 0; i < 3; i++)
			lookup(kind_ret, 32'h0000_7000 + i * 32'h4);
		drain();
		test_name = "ras_overflow";
		// Ninth call drops the first, last return finds the stack empty
		for (int i = 0; i < 9; i++)
			lookup(kind_call, 32'h0000_6800 + i * 32'h40);
		for (int i = 0; i < 9; i++)
			lookup(kind_ret, 32'h0000_7400 + i * 32'h4);
		drain();
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		lookup_valid = 1'b0;
		lookup_kind = kind_cond;
		lookup_pc = '0;
		retire_valid = 1'b0;
		retire_kind = kind_cond;
		retire_pc = '0;
		retire_target = '0;
		retire_taken = 1'b0;
		retire_correct = 1'b0;
		retire_tag = '0;
		errors = 0;
		test_name = "reset";
		rng = 32'hd0e6_ef05;
		m_ghr = '0;
		m_tail = '0;
		m_last_tag = '0;
		m_predicted = 1'b0;
		m_ras_ptr = 0;
		m_ras_count = 0;
		for (int i = 0; i < PHT_ENTRIES; i++)
			m_pht[i] = 2'd1;
		for (int i = 0; i < BTB_ENTRIES; i++)
			m_btb_valid[i] = 1'b0;
		fork
			check_predictions();
		join_none
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_latency();
		test_btb();
		test_gshare();
		test_history_recovery();
		test_ras();
		$display("all tests run, %0d errors", errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
